//--- hdl/syn_config.svh
`ifndef SYN_CONFIG_SVH
`define SYN_CONFIG_SVH

// Number of voices, two per part
`define SYN_CHANNELS 4

// clk_en pulses per output sample
`define SYN_SAMPLE_DIV 8

// clk_en pulses that busy stays high after a data write
`define SYN_BUSY_LEN 4

// Phase accumulator width
`define SYN_PHASE_W 20

// Sample ticks per timer B step
`define SYN_TMRB_PRE 16

`endif

//--- hdl/syn_pkg.sv
package syn_pkg;

	// Settings of one channel
	typedef struct packed {
		logic [10:0] fnum;
		logic [2:0]  block;
		// Attenuation as a right shift
		logic [3:0]  tl;
		// Bit 1 left, bit 0 right
		logic [1:0]  rl;
		logic        keyon;
	} chan_cfg_t;

	// Timer settings and flag clear pulses
	typedef struct packed {
		logic [9:0] value_a;
		logic [7:0] value_b;
		logic       load_a;
		logic       load_b;
		logic       irq_en_a;
		logic       irq_en_b;
		// One-cycle pulses
		logic       clr_a;
		logic       clr_b;
	} timer_cfg_t;

	// Attenuated sawtooth of one voice
	typedef logic signed [10:0] voice_t;

endpackage

//--- hdl/syn_mmr.sv
`timescale 1ns/10ps
`include "syn_config.svh"

module syn_mmr (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  clk_en,
	input  logic [7:0]                            din,
	input  logic [1:0]                            addr,
	input  logic                                  write,
	output logic                                  busy,
	output syn_pkg::chan_cfg_t [`SYN_CHANNELS-1:0] chan_cfg,
	output syn_pkg::timer_cfg_t                   timer_cfg,
	output logic                                  zero
);
	localparam int BUSY_W = $clog2(`SYN_BUSY_LEN);
	localparam int DIV_W  = $clog2(`SYN_SAMPLE_DIV);

	logic [7:0]        sel_reg;
	logic              part;
	logic [BUSY_W-1:0] busy_cnt;
	logic [DIV_W-1:0]  div_cnt;
	logic              data_wr;
	logic [1:0]        reg_ch;
	logic [1:0]        key_ch;

	// Data writes are ignored while busy
	assign data_wr = write && addr[0] && !busy;

	// Channel is part times two plus the low register bit
	assign reg_ch = {part, sel_reg[0]};
	// Key register carries its own channel select, bit 2 is the part
	assign key_ch = {din[2], din[0]};

	// Last clk_en pulse of each sample period
	assign zero = clk_en && (div_cnt == DIV_W'(`SYN_SAMPLE_DIV - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
		end else if (zero) begin
			div_cnt <= '0;
		end else if (clk_en) begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// Address writes are always accepted
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sel_reg <= '0;
			part    <= 1'b0;
		end else if (write && !addr[0]) begin
			sel_reg <= din;
			part    <= addr[1];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			busy_cnt <= '0;
		end else if (data_wr) begin
			busy     <= 1'b1;
			busy_cnt <= '0;
		end else if (busy && clk_en) begin
			if (busy_cnt == BUSY_W'(`SYN_BUSY_LEN - 1))
				busy <= 1'b0;
			busy_cnt <= busy_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			timer_cfg <= '0;
			for (int i = 0; i < `SYN_CHANNELS; i++) begin
				chan_cfg[i]    <= '0;
				chan_cfg[i].rl <= 2'b11;
			end
		end else begin
			// Clear bits only last one cycle
			timer_cfg.clr_a <= 1'b0;
			timer_cfg.clr_b <= 1'b0;
			if (data_wr) begin
				case (sel_reg)
					8'h24: timer_cfg.value_a[9:2] <= din;
					8'h25: timer_cfg.value_a[1:0] <= din[1:0];
					8'h26: timer_cfg.value_b <= din;
					8'h27: begin
						if (!part) begin
							timer_cfg.load_a   <= din[0];
							timer_cfg.load_b   <= din[1];
							timer_cfg.irq_en_a <= din[2];
							timer_cfg.irq_en_b <= din[3];
							timer_cfg.clr_a    <= din[4];
							timer_cfg.clr_b    <= din[5];
						end
					end
					8'h28: chan_cfg[key_ch].keyon <= din[4];
					8'h40, 8'h41: chan_cfg[reg_ch].tl <= din[3:0];
					8'hA0, 8'hA1: chan_cfg[reg_ch].fnum[7:0] <= din;
					8'hA4, 8'hA5: begin
						chan_cfg[reg_ch].block      <= din[5:3];
						chan_cfg[reg_ch].fnum[10:8] <= din[2:0];
					end
					8'hB4, 8'hB5: chan_cfg[reg_ch].rl <= din[7:6];
					default: ;
				endcase
			end
		end
	end

endmodule

//--- hdl/syn_timers.sv
`timescale 1ns/10ps
`include "syn_config.svh"

module syn_timers (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                zero,
	input  syn_pkg::timer_cfg_t timer_cfg,
	output logic                flag_a,
	output logic                flag_b,
	output logic                irq_n
);
	localparam int PRE_W = $clog2(`SYN_TMRB_PRE);

	logic [9:0]       cnt_a;
	logic [7:0]       cnt_b;
	logic [PRE_W-1:0] pre_b;
	logic             step_b;

	// Timer B moves once per prescaler wrap
	assign step_b = zero && (pre_b == PRE_W'(`SYN_TMRB_PRE - 1));

	// Timer A
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_a  <= '0;
			flag_a <= 1'b0;
		end else begin
			if (timer_cfg.clr_a)
				flag_a <= 1'b0;
			if (!timer_cfg.load_a) begin
				// Stopped counter tracks the start value
				cnt_a <= timer_cfg.value_a;
			end else if (zero) begin
				if (cnt_a == 10'd1023) begin
					cnt_a <= timer_cfg.value_a;
					if (timer_cfg.irq_en_a)
						flag_a <= 1'b1;
				end else begin
					cnt_a <= cnt_a + 1'b1;
				end
			end
		end
	end

	// Timer B and its prescaler
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_b  <= '0;
			pre_b  <= '0;
			flag_b <= 1'b0;
		end else begin
			if (timer_cfg.clr_b)
				flag_b <= 1'b0;
			if (!timer_cfg.load_b) begin
				cnt_b <= timer_cfg.value_b;
				pre_b <= '0;
			end else if (zero) begin
				pre_b <= step_b ? '0 : pre_b + 1'b1;
				if (step_b) begin
					if (cnt_b == 8'd255) begin
						cnt_b <= timer_cfg.value_b;
						if (timer_cfg.irq_en_b)
							flag_b <= 1'b1;
					end else begin
						cnt_b <= cnt_b + 1'b1;
					end
				end
			end
		end
	end

	assign irq_n = ~(flag_a | flag_b);

endmodule

//--- hdl/syn_voice.sv
`timescale 1ns/10ps
`include "syn_config.svh"

module syn_voice (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               zero,
	input  syn_pkg::chan_cfg_t cfg,
	output syn_pkg::voice_t    sample
);
	localparam int PW = `SYN_PHASE_W;

	logic [PW-1:0]      phase;
	logic [PW-1:0]      phase_nxt;
	logic [PW-1:0]      inc;
	logic               key_prev;
	logic signed [10:0] saw;

	// Increment is fnum scaled by the octave
	assign inc = PW'(cfg.fnum) << cfg.block;

	always_comb begin
		if (cfg.keyon && !key_prev)
			phase_nxt = inc;
		else if (cfg.keyon)
			phase_nxt = phase + inc;
		else
			phase_nxt = phase;
	end

	// Top phase bits as a signed ramp, then attenuate
	assign saw = $signed(phase_nxt[PW-1 -: 11]) >>> cfg.tl;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase    <= '0;
			key_prev <= 1'b0;
			sample   <= '0;
		end else if (zero) begin
			phase    <= phase_nxt;
			key_prev <= cfg.keyon;
			// Silent when keyed off
			sample   <= cfg.keyon ? saw : '0;
		end
	end

endmodule

//--- hdl/syn_mixer.sv
`timescale 1ns/10ps
`include "syn_config.svh"

module syn_mixer (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                zero,
	input  logic                                limiter_en,
	input  syn_pkg::voice_t [`SYN_CHANNELS-1:0] voices,
	input  logic [`SYN_CHANNELS-1:0][1:0]       pans,
	output logic signed [11:0]                  snd_left,
	output logic signed [11:0]                  snd_right,
	output logic                                snd_sample
);
	logic               zero_d;
	logic signed [12:0] sum_l;
	logic signed [12:0] sum_r;

	// Saturate to 12 bits, or keep the low bits when the limiter is off
	function automatic logic signed [11:0] fit(input logic signed [12:0] s, input logic lim);
		logic signed [11:0] r;
		if (!lim)
			r = s[11:0];
		else if (s > 13'sd2047)
			r = 12'sd2047;
		else if (s < -13'sd2048)
			r = -12'sd2048;
		else
			r = s[11:0];
		return r;
	endfunction

	always_comb begin
		sum_l = '0;
		sum_r = '0;
		for (int i = 0; i < `SYN_CHANNELS; i++) begin
			if (pans[i][1])
				sum_l = sum_l + 13'($signed(voices[i]));
			if (pans[i][0])
				sum_r = sum_r + 13'($signed(voices[i]));
		end
	end

	// Voices settle one cycle after zero, outputs follow one cycle later
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			zero_d     <= 1'b0;
			snd_sample <= 1'b0;
			snd_left   <= '0;
			snd_right  <= '0;
		end else begin
			zero_d     <= zero;
			snd_sample <= zero_d;
			if (zero_d) begin
				snd_left  <= fit(sum_l, limiter_en);
				snd_right <= fit(sum_r, limiter_en);
			end
		end
	end

endmodule

//--- hdl/syn_top.sv
`timescale 1ns/10ps
`include "syn_config.svh"

module syn_top (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               clk_en,
	input  logic [7:0]         din,
	input  logic [1:0]         addr,
	input  logic               write,
	input  logic               limiter_en,
	output logic               busy,
	output logic               flag_a,
	output logic               flag_b,
	output logic               irq_n,
	output logic signed [11:0] snd_left,
	output logic signed [11:0] snd_right,
	output logic               snd_sample
);
	syn_pkg::chan_cfg_t [`SYN_CHANNELS-1:0] chan_cfg;
	syn_pkg::timer_cfg_t                   timer_cfg;
	syn_pkg::voice_t [`SYN_CHANNELS-1:0]    voices;
	logic [`SYN_CHANNELS-1:0][1:0]          pans;
	logic                                  zero;

	syn_mmr i_mmr (
		.clk       (clk),
		.rst_n     (rst_n),
		.clk_en    (clk_en),
		.din       (din),
		.addr      (addr),
		.write     (write),
		.busy      (busy),
		.chan_cfg  (chan_cfg),
		.timer_cfg (timer_cfg),
		.zero      (zero)
	);

	syn_timers i_timers (
		.clk       (clk),
		.rst_n     (rst_n),
		.zero      (zero),
		.timer_cfg (timer_cfg),
		.flag_a    (flag_a),
		.flag_b    (flag_b),
		.irq_n     (irq_n)
	);

	// One voice per channel
	for (genvar i = 0; i < `SYN_CHANNELS; i++) begin : g_voice
		syn_voice i_voice (
			.clk    (clk),
			.rst_n  (rst_n),
			.zero   (zero),
			.cfg    (chan_cfg[i]),
			.sample (voices[i])
		);
		assign pans[i] = chan_cfg[i].rl;
	end

	syn_mixer i_mixer (
		.clk        (clk),
		.rst_n      (rst_n),
		.zero       (zero),
		.limiter_en (limiter_en),
		.voices     (voices),
		.pans       (pans),
		.snd_left   (snd_left),
		.snd_right  (snd_right),
		.snd_sample (snd_sample)
	);

endmodule

//--- tb/syn_checker.sv
`timescale 1ns/10ps
`include "syn_config.svh"

module syn_checker (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               clk_en,
	input  logic [7:0]         din,
	input  logic [1:0]         addr,
	input  logic               write,
	input  logic               limiter_en,
	input  logic               busy,
	input  logic               flag_a,
	input  logic               flag_b,
	input  logic               irq_n,
	input  logic signed [11:0] snd_left,
	input  logic signed [11:0] snd_right,
	input  logic               snd_sample,
	output int                 checks,
	output int                 mismatches
);
	localparam int N  = `SYN_CHANNELS;
	localparam int PW = `SYN_PHASE_W;

	// Register model
	syn_pkg::chan_cfg_t  cfg_m [N];
	syn_pkg::timer_cfg_t tcfg_m;
	logic [7:0]          sel_m;
	logic                part_m;
	logic                busy_m;
	int                  busy_cnt;
	int                  div_cnt;

	// Voice and timer model
	logic [PW-1:0]       phase_m [N];
	logic                key_prev_m [N];
	logic signed [10:0]  voice_m [N];
	logic [9:0]          cnt_a;
	logic [7:0]          cnt_b;
	int                  pre_b;
	logic                fa;
	logic                fb;

	// Mixer pipeline, one stage per cycle after zero
	logic                mix_now;
	logic                out_now;
	logic signed [11:0]  exp_l;
	logic signed [11:0]  exp_r;

	// Sawtooth from the top phase bits, attenuated by tl
	function automatic logic signed [10:0] saw_ref(input logic [PW-1:0] ph, input logic [3:0] tl);
		logic signed [10:0] top;
		top = ph[PW-1 -: 11];
		return top >>> tl;
	endfunction

	// Sum of the voices panned to one side, rl bit 1 is left
	function automatic logic signed [11:0] mix_ref(input int side, input logic lim);
		int sum;
		sum = 0;
		for (int i = 0; i < N; i++) begin
			if (cfg_m[i].rl[side])
				sum = sum + int'(voice_m[i]);
		end
		if (lim && sum > 2047)
			sum = 2047;
		else if (lim && sum < -2048)
			sum = -2048;
		return sum[11:0];
	endfunction

	task automatic check_val(input string name, input logic [11:0] expv, input logic [11:0] actv);
		checks++;
		if (actv !== expv) begin
			mismatches++;
			$display("Mismatch %s: expected %h, actual %h at %0t", name, expv, actv, $time);
		end
	endtask

	task automatic reset_model();
		tcfg_m   = '0;
		sel_m    = '0;
		part_m   = 1'b0;
		busy_m   = 1'b0;
		busy_cnt = 0;
		div_cnt  = 0;
		cnt_a    = '0;
		cnt_b    = '0;
		pre_b    = 0;
		fa       = 1'b0;
		fb       = 1'b0;
		mix_now  = 1'b0;
		out_now  = 1'b0;
		exp_l    = '0;
		exp_r    = '0;
		for (int i = 0; i < N; i++) begin
			cfg_m[i]      = '0;
			cfg_m[i].rl   = 2'b11;
			phase_m[i]    = '0;
			key_prev_m[i] = 1'b0;
			voice_m[i]    = '0;
		end
	endtask

	task automatic step_timers(input logic zero_now);
		if (tcfg_m.clr_a)
			fa = 1'b0;
		if (!tcfg_m.load_a) begin
			cnt_a = tcfg_m.value_a;
		end else if (zero_now) begin
			if (cnt_a == 10'd1023) begin
				cnt_a = tcfg_m.value_a;
				fa    = fa | tcfg_m.irq_en_a;
			end else begin
				cnt_a = cnt_a + 10'd1;
			end
		end
		if (tcfg_m.clr_b)
			fb = 1'b0;
		if (!tcfg_m.load_b) begin
			cnt_b = tcfg_m.value_b;
			pre_b = 0;
		end else if (zero_now && pre_b == `SYN_TMRB_PRE - 1) begin
			pre_b = 0;
			if (cnt_b == 8'd255) begin
				cnt_b = tcfg_m.value_b;
				fb    = fb | tcfg_m.irq_en_b;
			end else begin
				cnt_b = cnt_b + 8'd1;
			end
		end else if (zero_now) begin
			pre_b++;
		end
	endtask

	task automatic step_voices();
		logic [PW-1:0] inc;
		for (int i = 0; i < N; i++) begin
			inc = PW'(cfg_m[i].fnum) << cfg_m[i].block;
			if (cfg_m[i].keyon && !key_prev_m[i])
				phase_m[i] = inc;
			else if (cfg_m[i].keyon)
				phase_m[i] = phase_m[i] + inc;
			key_prev_m[i] = cfg_m[i].keyon;
			voice_m[i] = cfg_m[i].keyon ? saw_ref(phase_m[i], cfg_m[i].tl) : 11'sd0;
		end
	endtask

	task automatic apply_write();
		case (sel_m)
			8'h24: tcfg_m.value_a[9:2] = din;
			8'h25: tcfg_m.value_a[1:0] = din[1:0];
			8'h26: tcfg_m.value_b = din;
			8'h27: begin
				if (!part_m) begin
					{tcfg_m.irq_en_b, tcfg_m.irq_en_a} = din[3:2];
					{tcfg_m.load_b, tcfg_m.load_a}     = din[1:0];
					{tcfg_m.clr_b, tcfg_m.clr_a}       = din[5:4];
				end
			end
			8'h28: cfg_m[{din[2], din[0]}].keyon = din[4];
			8'h40, 8'h41: cfg_m[{part_m, sel_m[0]}].tl = din[3:0];
			8'hA0, 8'hA1: cfg_m[{part_m, sel_m[0]}].fnum[7:0] = din;
			8'hA4, 8'hA5: begin
				cfg_m[{part_m, sel_m[0]}].block      = din[5:3];
				cfg_m[{part_m, sel_m[0]}].fnum[10:8] = din[2:0];
			end
			8'hB4, 8'hB5: cfg_m[{part_m, sel_m[0]}].rl = din[7:6];
			default: ;
		endcase
	endtask

	initial begin
		checks     = 0;
		mismatches = 0;
		reset_model();
	end

	// Inputs and outputs are both settled at the falling edge
	always @(negedge clk) begin
		logic zero_now;
		logic data_ok;
		if (!rst_n)
			reset_model();
		zero_now = rst_n && clk_en && (div_cnt == `SYN_SAMPLE_DIV - 1);
		data_ok  = rst_n && write && addr[0] && !busy_m;
		check_val("busy", 12'(busy_m), 12'(busy));
		check_val("flag_a", 12'(fa), 12'(flag_a));
		check_val("flag_b", 12'(fb), 12'(flag_b));
		check_val("irq_n", 12'(!(fa || fb)), 12'(irq_n));
		check_val("snd_sample", 12'(out_now), 12'(snd_sample));
		if (out_now || !rst_n) begin
			check_val("snd_left", exp_l, snd_left);
			check_val("snd_right", exp_r, snd_right);
		end
		if (rst_n) begin
			if (mix_now) begin
				exp_l = mix_ref(1, limiter_en);
				exp_r = mix_ref(0, limiter_en);
			end
			out_now = mix_now;
			mix_now = zero_now;
			step_timers(zero_now);
			if (zero_now)
				step_voices();
			tcfg_m.clr_a = 1'b0;
			tcfg_m.clr_b = 1'b0;
			if (write && !addr[0]) begin
				sel_m  = din;
				part_m = addr[1];
			end else if (data_ok) begin
				apply_write();
			end
			if (data_ok) begin
				busy_m   = 1'b1;
				busy_cnt = 0;
			end else if (busy_m && clk_en) begin
				if (busy_cnt == `SYN_BUSY_LEN - 1)
					busy_m = 1'b0;
				busy_cnt++;
			end
			if (zero_now)
				div_cnt = 0;
			else if (clk_en)
				div_cnt++;
		end
	end

endmodule

//--- tb/tb_syn.sv
`timescale 1ns/10ps
`include "syn_config.svh"

module tb_syn;
	// Test length in samples including write overhead
	localparam int TEST_SAMPLES = 180;
	localparam int WATCHDOG_NS  = (TEST_SAMPLES * `SYN_SAMPLE_DIV * 3 + 1000) * 40;

	logic               clk;
	logic               rst_n;
	logic               clk_en;
	logic [7:0]         din;
	logic [1:0]         addr;
	logic               write;
	logic               limiter_en;
	logic               busy;
	logic               flag_a;
	logic               flag_b;
	logic               irq_n;
	logic signed [11:0] snd_left;
	logic signed [11:0] snd_right;
	logic               snd_sample;
	int                 checks;
	int                 mismatches;
	int                 other_errors;
	logic [31:0]        lfsr;

	syn_top i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.clk_en     (clk_en),
		.din        (din),
		.addr       (addr),
		.write      (write),
		.limiter_en (limiter_en),
		.busy       (busy),
		.flag_a     (flag_a),
		.flag_b     (flag_b),
		.irq_n      (irq_n),
		.snd_left   (snd_left),
		.snd_right  (snd_right),
		.snd_sample (snd_sample)
	);

	syn_checker i_checker (
		.clk        (clk),
		.rst_n      (rst_n),
		.clk_en     (clk_en),
		.din        (din),
		.addr       (addr),
		.write      (write),
		.limiter_en (limiter_en),
		.busy       (busy),
		.flag_a     (flag_a),
		.flag_b     (flag_b),
		.irq_n      (irq_n),
		.snd_left   (snd_left),
		.snd_right  (snd_right),
		.snd_sample (snd_sample),
		.checks     (checks),
		.mismatches (mismatches)
	);

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	task automatic wait_samples(input int n);
		repeat (n) begin
			tick();
			while (!snd_sample)
				tick();
		end
	endtask

	task automatic write_reg(input logic part, input logic [7:0] num, input logic [7:0] data,
			input logic wait_idle);
		int n;
		n = 0;
		while (wait_idle && busy && n < 100) begin
			tick();
			n++;
		end
		if (wait_idle && busy) begin
			other_errors++;
			$display("busy did not fall before writing register %h", num);
		end
		write = 1'b1;
		addr  = {part, 1'b0};
		din   = num;
		tick();
		addr  = {part, 1'b1};
		din   = data;
		tick();
		write = 1'b0;
	endtask

	task automatic set_chan(input int ch, input logic [10:0] fnum, input logic [2:0] block,
			input logic [3:0] tl, input logic [1:0] rl);
		logic [7:0] lo;
		lo = {7'b0, ch[0]};
		write_reg(ch[1], 8'hA0 | lo, fnum[7:0], 1'b1);
		write_reg(ch[1], 8'hA4 | lo, {2'b00, block, fnum[10:8]}, 1'b1);
		write_reg(ch[1], 8'h40 | lo, {4'h0, tl}, 1'b1);
		write_reg(ch[1], 8'hB4 | lo, {rl, 6'h00}, 1'b1);
	endtask

	task automatic key_chan(input int ch, input logic on);
		write_reg(1'b0, 8'h28, {3'b000, on, 1'b0, ch[1], 1'b0, ch[0]}, 1'b1);
	endtask

	task automatic wait_flag(input logic use_b, input int max_cycles);
		int n;
		n = 0;
		while (!(use_b ? flag_b : flag_a) && n < max_cycles) begin
			tick();
			n++;
		end
		if (!(use_b ? flag_b : flag_a)) begin
			other_errors++;
			$display("Timer flag %s did not rise in time", use_b ? "B" : "A");
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// One clk_en pulse every third cycle
	initial begin
		int en_cnt;
		en_cnt = 0;
		clk_en = 1'b0;
		forever begin
			tick();
			clk_en = (en_cnt == 2);
			en_cnt = (en_cnt == 2) ? 0 : en_cnt + 1;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the test sequence finished");
		$display("Checks failed");
		$finish;
	end

	initial begin
		lfsr         = 32'h91df;
		other_errors = 0;
		rst_n        = 1'b0;
		din          = '0;
		addr         = '0;
		write        = 1'b0;
		limiter_en   = 1'b1;
		repeat (10) @(posedge clk);
		#2;
		rst_n = 1'b1;
		// Silence after reset
		wait_samples(3);

		// Single voice and a restart
		set_chan(0, 11'(rand_bits(11)), 3'(rand_bits(3)), 4'h0, 2'b11);
		key_chan(0, 1'b1);
		wait_samples(20);
		key_chan(0, 1'b0);
		wait_samples(2);
		key_chan(0, 1'b1);
		wait_samples(10);

		// Random pan and level on all four channels
		for (int ch = 0; ch < `SYN_CHANNELS; ch++) begin
			set_chan(ch, 11'(rand_bits(11)), 3'(rand_bits(3)), {1'b0, 3'(rand_bits(3))},
				2'(rand_bits(2)));
			key_chan(ch, 1'b1);
		end
		wait_samples(20);

		// Full-level voices overflow the 12-bit sum
		for (int ch = 0; ch < `SYN_CHANNELS; ch++) begin
			key_chan(ch, 1'b0);
			set_chan(ch, 11'h7FF, 3'd5, 4'h0, 2'b11);
		end
		for (int ch = 0; ch < `SYN_CHANNELS; ch++)
			key_chan(ch, 1'b1);
		wait_samples(16);
		limiter_en = 1'b0;
		wait_samples(16);
		limiter_en = 1'b1;

		// Timer A starts at 1020 and timer B at 254
		write_reg(1'b0, 8'h24, 8'hFF, 1'b1);
		write_reg(1'b0, 8'h25, 8'h00, 1'b1);
		write_reg(1'b0, 8'h26, 8'd254, 1'b1);
		write_reg(1'b0, 8'h27, 8'h0F, 1'b1);
		wait_flag(1'b0, 10 * `SYN_SAMPLE_DIV * 3);
		// Timer A keeps wrapping with its flag disabled and cleared while B runs on
		write_reg(1'b0, 8'h27, 8'h1B, 1'b1);
		wait_flag(1'b1, 40 * `SYN_SAMPLE_DIV * 3);
		write_reg(1'b0, 8'h27, 8'h20, 1'b1);
		wait_samples(2);

		// Second data write lands inside the busy window
		write_reg(1'b0, 8'h40, 8'h00, 1'b1);
		if (!busy) begin
			other_errors++;
			$display("busy was not high after an accepted data write");
		end
		write_reg(1'b0, 8'hA0, 8'h55, 1'b0);
		wait_samples(6);

		tick();
		$display("Closing: %0d checks, %0d mismatches, %0d other errors",
			checks, mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0 && checks > 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- filelist.f
+incdir+hdl
hdl/syn_pkg.sv
hdl/syn_mmr.sv
hdl/syn_timers.sv
hdl/syn_voice.sv
hdl/syn_mixer.sv
hdl/syn_top.sv
tb/syn_checker.sv
tb/tb_syn.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the tone synthesizer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -f filelist.f --top-module tb_syn \
	-Mdir obj_dir -o tb_syn > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_syn > sim.log 2>&1 || { cat sim.log; echo "Simulation did not complete"; exit 1; }
cat sim.log
grep -q "Checks failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
